//--- verilog/llc_macros.svh
`ifndef LLC_MACROS_SVH
`define LLC_MACROS_SVH

// Address width of coherence and DMA messages.
`define LLC_ADDR_BITS 16

// Data word carried by responses, DMA requests and cfg writes.
`define LLC_DATA_BITS 32

`define LLC_ID_BITS 4

`define LLC_CFG_ADDR_BITS 2

`endif

//--- verilog/llc_pkg.sv
`default_nettype none

`include "llc_macros.svh"

package llc_pkg;

    typedef struct packed {
        logic is_flush;
    } llc_rst_tb_t;

    typedef struct packed {
        logic [`LLC_ADDR_BITS-1:0] addr;
        logic [`LLC_ID_BITS-1:0]   id;
    } llc_req_t;

    typedef struct packed {
        logic [`LLC_ADDR_BITS-1:0] addr;
        logic [`LLC_DATA_BITS-1:0] data;
    } llc_rsp_t;

    typedef struct packed {
        logic [`LLC_ADDR_BITS-1:0] addr;
        logic                      write;
        logic [`LLC_DATA_BITS-1:0] data;
    } llc_dma_req_t;

    typedef enum logic [3:0] {
        NONE             = 4'd0,
        RST              = 4'd1,
        RSP              = 4'd2,
        REQ              = 4'd3,
        DMA_REQ          = 4'd4,
        RST_RESUME       = 4'd5,
        FLUSH_RESUME     = 4'd6,
        DMA_READ_RESUME  = 4'd7,
        DMA_WRITE_RESUME = 4'd8
    } llc_kind_t;

    // One-hot action flags; from_stalled and look qualify the action.
    typedef struct packed {
        logic is_rst_to_get;
        logic is_rsp_to_get;
        logic is_req_to_get;
        logic is_dma_req_to_get;
        logic is_rst_to_resume;
        logic is_flush_to_resume;
        logic is_dma_read_to_resume;
        logic is_dma_write_to_resume;
        logic from_stalled;
        logic look;
    } llc_decision_t;

    typedef struct packed {
        logic recall_pending;
        logic recall_valid;
        logic dma_read_pending;
        logic dma_write_pending;
        logic rst_stall;
        logic flush_stall;
        logic req_stall;
        logic req_in_stalled_valid;
    } llc_ctrl_t;

    typedef struct packed {
        logic                      valid;
        llc_kind_t                 kind;
        logic                      look;
        logic [`LLC_ADDR_BITS-1:0] addr;
        logic [`LLC_DATA_BITS-1:0] data;
        logic [`LLC_ID_BITS-1:0]   id;
        logic                      write;
    } llc_dispatch_t;

endpackage

`default_nettype wire

//--- verilog/llc_input_buffer.sv
`default_nettype none
`timescale 1ns/1ps

module llc_input_buffer #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_ready,
    output logic     buf_valid,
    output payload_t buf_data,
    input  logic     pop
);

    logic push;

    // Accepting only when empty means push and pop never meet.
    assign in_ready = !buf_valid;
    assign push     = in_valid && in_ready;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            buf_valid <= 1'b0;
        end else if (push) begin
            buf_valid <= 1'b1;
        end else if (pop) begin
            buf_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            buf_data <= in_data;
        end
    end

endmodule

`default_nettype wire

//--- verilog/llc_ctrl_regs.sv
`default_nettype none
`timescale 1ns/1ps
`include "llc_macros.svh"

module llc_ctrl_regs import llc_pkg::*; (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          cfg_wr,
    input  logic [`LLC_CFG_ADDR_BITS-1:0] cfg_addr,
    input  logic [`LLC_DATA_BITS-1:0]     cfg_wdata,
    input  llc_decision_t                 decision,
    output llc_ctrl_t                     ctrl,
    output llc_req_t                      stalled_req
);

    llc_ctrl_t ctrl_next;
    logic      any_resume;

    assign any_resume = decision.is_rst_to_resume | decision.is_flush_to_resume |
                        decision.is_dma_read_to_resume | decision.is_dma_write_to_resume;

    always_comb begin
        ctrl_next = ctrl;

        // Consumed state first, so a cfg write to the same bits wins.
        if (decision.is_rst_to_resume) ctrl_next.rst_stall = 1'b0;
        if (decision.is_flush_to_resume) ctrl_next.flush_stall = 1'b0;
        if (decision.from_stalled) ctrl_next.req_in_stalled_valid = 1'b0;
        if (decision.is_dma_read_to_resume) ctrl_next.dma_read_pending = 1'b0;
        if (decision.is_dma_write_to_resume) ctrl_next.dma_write_pending = 1'b0;
        if (any_resume && ctrl.recall_pending) begin
            ctrl_next.recall_pending = 1'b0;
            ctrl_next.recall_valid   = 1'b0;
        end

        if (cfg_wr) begin
            case (cfg_addr)
                2'd0: begin
                    ctrl_next.rst_stall   = cfg_wdata[0];
                    ctrl_next.flush_stall = cfg_wdata[1];
                    ctrl_next.req_stall   = cfg_wdata[2];
                end
                2'd1: begin
                    ctrl_next.recall_pending = cfg_wdata[0];
                    ctrl_next.recall_valid   = cfg_wdata[1];
                end
                2'd2: begin
                    ctrl_next.dma_read_pending  = cfg_wdata[0];
                    ctrl_next.dma_write_pending = cfg_wdata[1];
                end
                default: ctrl_next.req_in_stalled_valid = 1'b1;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ctrl <= '0;
        end else begin
            ctrl <= ctrl_next;
        end
    end

    // Slot payload takes addr from the low bits and id from just above it.
    always_ff @(posedge clk) begin
        if (cfg_wr && cfg_addr == 2'd3) begin
            stalled_req.addr <= cfg_wdata[`LLC_ADDR_BITS-1:0];
            stalled_req.id   <= cfg_wdata[`LLC_ADDR_BITS +: `LLC_ID_BITS];
        end
    end

endmodule

`default_nettype wire

//--- verilog/llc_input_decoder.sv
`default_nettype none
`timescale 1ns/1ps

module llc_input_decoder import llc_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          rst_tb_valid,
    input  logic          rsp_valid,
    input  logic          req_valid,
    input  logic          dma_req_valid,
    input  llc_ctrl_t     ctrl,
    input  logic          decode_en,
    output logic          rst_tb_pop,
    output logic          rsp_pop,
    output logic          req_pop,
    output logic          dma_req_pop,
    output llc_decision_t decision
);

    logic          can_get_rst_tb;
    logic          can_get_rsp;
    logic          can_get_req;
    logic          can_get_dma_req;
    logic          no_dma_pending;
    logic          fresh;
    llc_decision_t decision_next;
    llc_decision_t decision_held;

    assign no_dma_pending = !ctrl.dma_read_pending && !ctrl.dma_write_pending;

    // Channel valids are seen one cycle after the buffer fills.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            can_get_rst_tb  <= 1'b0;
            can_get_rsp     <= 1'b0;
            can_get_req     <= 1'b0;
            can_get_dma_req <= 1'b0;
        end else begin
            can_get_rst_tb  <= rst_tb_valid;
            can_get_rsp     <= rsp_valid;
            can_get_req     <= req_valid;
            can_get_dma_req <= dma_req_valid;
        end
    end

    always_comb begin
        decision_next = '0;

        if (ctrl.recall_pending) begin
            if (!ctrl.recall_valid) begin
                decision_next.is_rsp_to_get = can_get_rsp;
            end else if (ctrl.dma_read_pending) begin
                decision_next.is_dma_read_to_resume = 1'b1;
            end else if (ctrl.dma_write_pending) begin
                decision_next.is_dma_write_to_resume = 1'b1;
            end
        end else if (ctrl.rst_stall) begin
            decision_next.is_rst_to_resume = 1'b1;
        end else if (ctrl.flush_stall) begin
            decision_next.is_flush_to_resume = 1'b1;
        end else if (can_get_rst_tb && no_dma_pending) begin
            decision_next.is_rst_to_get = 1'b1;
        end else if (can_get_rsp) begin
            decision_next.is_rsp_to_get = 1'b1;
        end else if (!ctrl.req_stall && (ctrl.req_in_stalled_valid || can_get_req)) begin
            // Stalled slot has precedence over a fresh request.
            decision_next.is_req_to_get = 1'b1;
            decision_next.from_stalled  = ctrl.req_in_stalled_valid;
        end else if (ctrl.dma_read_pending) begin
            decision_next.is_dma_read_to_resume = 1'b1;
        end else if (ctrl.dma_write_pending) begin
            decision_next.is_dma_write_to_resume = can_get_dma_req;
        end else if (can_get_dma_req && !ctrl.req_stall) begin
            decision_next.is_dma_req_to_get = 1'b1;
        end

        decision_next.look = decision_next.is_flush_to_resume |
                             decision_next.is_rsp_to_get |
                             decision_next.is_req_to_get |
                             decision_next.is_dma_req_to_get |
                             ((decision_next.is_dma_read_to_resume |
                               decision_next.is_dma_write_to_resume) & ~ctrl.recall_pending);
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            decision_held <= '0;
            fresh         <= 1'b0;
        end else begin
            fresh <= decode_en;
            if (decode_en) begin
                decision_held <= decision_next;
            end
        end
    end

    // The held action is presented for one cycle, so it is consumed once.
    assign decision = fresh ? decision_held : '0;

    assign rst_tb_pop = decision.is_rst_to_get;
    assign rsp_pop    = decision.is_rsp_to_get;
    assign req_pop    = decision.is_req_to_get & ~decision.from_stalled;

    // A write resume outside recall takes its DMA request; look marks that case.
    assign dma_req_pop = decision.is_dma_req_to_get |
                         (decision.is_dma_write_to_resume & decision.look);

endmodule

`default_nettype wire

//--- verilog/llc_msg_select.sv
`default_nettype none
`timescale 1ns/1ps

module llc_msg_select import llc_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  llc_decision_t decision,
    input  llc_rst_tb_t   rst_tb_data,
    input  llc_rsp_t      rsp_data,
    input  llc_req_t      req_data,
    input  llc_req_t      stalled_req,
    input  llc_dma_req_t  dma_req_data,
    output llc_dispatch_t dispatch
);

    llc_dispatch_t dispatch_next;
    llc_req_t      req_src;

    assign req_src = decision.from_stalled ? stalled_req : req_data;

    always_comb begin
        dispatch_next      = '0;
        dispatch_next.look = decision.look;

        if (decision.is_rst_to_get) begin
            dispatch_next.kind = RST;
            // Flush and plain reset share a kind; the flush bit rides in data.
            dispatch_next.data = {{(`LLC_DATA_BITS-1){1'b0}}, rst_tb_data.is_flush};
        end else if (decision.is_rsp_to_get) begin
            dispatch_next.kind = RSP;
            dispatch_next.addr = rsp_data.addr;
            dispatch_next.data = rsp_data.data;
        end else if (decision.is_req_to_get) begin
            dispatch_next.kind = REQ;
            dispatch_next.addr = req_src.addr;
            dispatch_next.id   = req_src.id;
        end else if (decision.is_dma_req_to_get) begin
            dispatch_next.kind  = DMA_REQ;
            dispatch_next.addr  = dma_req_data.addr;
            dispatch_next.write = dma_req_data.write;
            dispatch_next.data  = dma_req_data.data;
        end else if (decision.is_rst_to_resume) begin
            dispatch_next.kind = RST_RESUME;
        end else if (decision.is_flush_to_resume) begin
            dispatch_next.kind = FLUSH_RESUME;
        end else if (decision.is_dma_read_to_resume) begin
            dispatch_next.kind = DMA_READ_RESUME;
        end else if (decision.is_dma_write_to_resume) begin
            dispatch_next.kind = DMA_WRITE_RESUME;
        end

        dispatch_next.valid = (dispatch_next.kind != NONE);
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            dispatch <= '0;
        end else begin
            dispatch <= dispatch_next;
        end
    end

endmodule

`default_nettype wire

//--- verilog/llc_front_end.sv
`default_nettype none
`timescale 1ns/1ps
`include "llc_macros.svh"

module llc_front_end import llc_pkg::*; (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          rst_tb_in_valid,
    input  llc_rst_tb_t                   rst_tb_in,
    output logic                          rst_tb_in_ready,
    input  logic                          rsp_in_valid,
    input  llc_rsp_t                      rsp_in,
    output logic                          rsp_in_ready,
    input  logic                          req_in_valid,
    input  llc_req_t                      req_in,
    output logic                          req_in_ready,
    input  logic                          dma_req_in_valid,
    input  llc_dma_req_t                  dma_req_in,
    output logic                          dma_req_in_ready,
    input  logic                          cfg_wr,
    input  logic [`LLC_CFG_ADDR_BITS-1:0] cfg_addr,
    input  logic [`LLC_DATA_BITS-1:0]     cfg_wdata,
    input  logic                          decode_en,
    output llc_dispatch_t                 dispatch
);

    logic          rst_tb_valid;
    logic          rsp_valid;
    logic          req_valid;
    logic          dma_req_valid;
    logic          rst_tb_pop;
    logic          rsp_pop;
    logic          req_pop;
    logic          dma_req_pop;
    llc_rst_tb_t   rst_tb_data;
    llc_rsp_t      rsp_data;
    llc_req_t      req_data;
    llc_dma_req_t  dma_req_data;
    llc_req_t      stalled_req;
    llc_ctrl_t     ctrl;
    llc_decision_t decision;

    llc_input_buffer #(.payload_t(llc_rst_tb_t)) rst_tb_buf (
        .clk(clk), .rst(rst),
        .in_valid(rst_tb_in_valid), .in_data(rst_tb_in), .in_ready(rst_tb_in_ready),
        .buf_valid(rst_tb_valid), .buf_data(rst_tb_data), .pop(rst_tb_pop)
    );

    llc_input_buffer #(.payload_t(llc_rsp_t)) rsp_buf (
        .clk(clk), .rst(rst),
        .in_valid(rsp_in_valid), .in_data(rsp_in), .in_ready(rsp_in_ready),
        .buf_valid(rsp_valid), .buf_data(rsp_data), .pop(rsp_pop)
    );

    llc_input_buffer #(.payload_t(llc_req_t)) req_buf (
        .clk(clk), .rst(rst),
        .in_valid(req_in_valid), .in_data(req_in), .in_ready(req_in_ready),
        .buf_valid(req_valid), .buf_data(req_data), .pop(req_pop)
    );

    llc_input_buffer #(.payload_t(llc_dma_req_t)) dma_req_buf (
        .clk(clk), .rst(rst),
        .in_valid(dma_req_in_valid), .in_data(dma_req_in), .in_ready(dma_req_in_ready),
        .buf_valid(dma_req_valid), .buf_data(dma_req_data), .pop(dma_req_pop)
    );

    llc_ctrl_regs ctrl_regs (
        .clk(clk), .rst(rst),
        .cfg_wr(cfg_wr), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
        .decision(decision), .ctrl(ctrl), .stalled_req(stalled_req)
    );

    llc_input_decoder decoder (
        .clk(clk), .rst(rst),
        .rst_tb_valid(rst_tb_valid), .rsp_valid(rsp_valid),
        .req_valid(req_valid), .dma_req_valid(dma_req_valid),
        .ctrl(ctrl), .decode_en(decode_en),
        .rst_tb_pop(rst_tb_pop), .rsp_pop(rsp_pop),
        .req_pop(req_pop), .dma_req_pop(dma_req_pop),
        .decision(decision)
    );

    llc_msg_select msg_select (
        .clk(clk), .rst(rst), .decision(decision),
        .rst_tb_data(rst_tb_data), .rsp_data(rsp_data), .req_data(req_data),
        .stalled_req(stalled_req), .dma_req_data(dma_req_data),
        .dispatch(dispatch)
    );

endmodule

`default_nettype wire

//--- verification/llc_front_end_checker.sv
`default_nettype none
`timescale 1ns/1ps

module llc_front_end_checker import llc_pkg::*; (
    input logic          clk,
    input logic          rst,
    input logic          decode_en,
    input llc_decision_t decision,
    input logic [3:0]    pops,
    input llc_dispatch_t dispatch
);

    // Get and resume flags sit above from_stalled and look.
    one_action: assert property (@(posedge clk) disable iff (!rst)
        $onehot0(decision[9:2]))
        else $error("More than one decision flag is high");

    pop_single: assert property (@(posedge clk) disable iff (!rst)
        (pops & $past(pops)) == 4'b0)
        else $error("A pop lasted longer than one cycle");

    dispatch_timing: assert property (@(posedge clk) disable iff (!rst)
        dispatch.valid |-> $past(decode_en, 2))
        else $error("Dispatch valid does not follow decode_en by two cycles");

    reset_quiet: assert property (@(posedge clk)
        $rose(rst) |-> (decision == '0 && !dispatch.valid && !dispatch.look))
        else $error("Outputs active right after reset");

endmodule

bind llc_input_decoder llc_front_end_checker decoder_chk (
    .clk(clk), .rst(rst), .decode_en(decode_en), .decision(decision),
    .pops({rst_tb_pop, rsp_pop, req_pop, dma_req_pop}), .dispatch('0)
);

bind llc_front_end llc_front_end_checker top_chk (
    .clk(clk), .rst(rst), .decode_en(decode_en), .decision(decision),
    .pops({rst_tb_pop, rsp_pop, req_pop, dma_req_pop}), .dispatch(dispatch)
);

`default_nettype wire

//--- verification/llc_front_end_tb.sv
`default_nettype none
`timescale 1ns/1ps
`include "llc_macros.svh"

module llc_front_end_tb import llc_pkg::*; ();

    localparam int NUM_DECODES     = 80;
    localparam int WATCHDOG_CYCLES = NUM_DECODES * 8 + 400;

    logic                          clk;
    logic                          rst;
    logic                          rst_tb_in_valid;
    llc_rst_tb_t                   rst_tb_in;
    logic                          rst_tb_in_ready;
    logic                          rsp_in_valid;
    llc_rsp_t                      rsp_in;
    logic                          rsp_in_ready;
    logic                          req_in_valid;
    llc_req_t                      req_in;
    logic                          req_in_ready;
    logic                          dma_req_in_valid;
    llc_dma_req_t                  dma_req_in;
    logic                          dma_req_in_ready;
    logic                          cfg_wr;
    logic [`LLC_CFG_ADDR_BITS-1:0] cfg_addr;
    logic [`LLC_DATA_BITS-1:0]     cfg_wdata;
    logic                          decode_en;
    llc_dispatch_t                 dispatch;

    // Model of the control flags, buffer occupancy (rst_tb, rsp, req, dma) and payloads.
    llc_ctrl_t     m_ctrl;
    logic [3:0]    m_occ;
    llc_rst_tb_t   m_rst_tb;
    llc_rsp_t      m_rsp;
    llc_req_t      m_req;
    llc_req_t      m_stalled;
    llc_dma_req_t  m_dma;
    int            errors;
    logic [15:0]   lfsr_state;
    llc_dispatch_t exp_next;
    llc_dispatch_t exp_a;
    llc_dispatch_t exp_b;
    string         exp_name;
    string         name_a;
    string         name_b;
    logic          pend;
    logic          due;

    llc_front_end dut0 (
        .clk(clk), .rst(rst),
        .rst_tb_in_valid(rst_tb_in_valid), .rst_tb_in(rst_tb_in),
        .rst_tb_in_ready(rst_tb_in_ready),
        .rsp_in_valid(rsp_in_valid), .rsp_in(rsp_in), .rsp_in_ready(rsp_in_ready),
        .req_in_valid(req_in_valid), .req_in(req_in), .req_in_ready(req_in_ready),
        .dma_req_in_valid(dma_req_in_valid), .dma_req_in(dma_req_in),
        .dma_req_in_ready(dma_req_in_ready),
        .cfg_wr(cfg_wr), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
        .decode_en(decode_en), .dispatch(dispatch)
    );

    always #5 clk = ~clk;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("ERROR %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // Expected dispatch by the priority rules.
    function automatic llc_dispatch_t ref_dispatch(input llc_ctrl_t c, input logic [3:0] occ);
        llc_dispatch_t d;
        llc_req_t      src;
        logic          no_dma;
        d      = '0;
        no_dma = !c.dma_read_pending && !c.dma_write_pending;
        if (c.recall_pending) begin
            if (!c.recall_valid) begin
                if (occ[2]) d.kind = RSP;
            end else if (c.dma_read_pending) begin
                d.kind = DMA_READ_RESUME;
            end else if (c.dma_write_pending) begin
                d.kind = DMA_WRITE_RESUME;
            end
        end else if (c.rst_stall) begin
            d.kind = RST_RESUME;
        end else if (c.flush_stall) begin
            d.kind = FLUSH_RESUME;
        end else if (occ[3] && no_dma) begin
            d.kind = RST;
        end else if (occ[2]) begin
            d.kind = RSP;
        end else if (!c.req_stall && (c.req_in_stalled_valid || occ[1])) begin
            d.kind = REQ;
        end else if (c.dma_read_pending) begin
            d.kind = DMA_READ_RESUME;
        end else if (c.dma_write_pending) begin
            if (occ[0]) d.kind = DMA_WRITE_RESUME;
        end else if (occ[0] && !c.req_stall) begin
            d.kind = DMA_REQ;
        end
        src = c.req_in_stalled_valid ? m_stalled : m_req;
        case (d.kind)
            RST: d.data = {{(`LLC_DATA_BITS-1){1'b0}}, m_rst_tb.is_flush};
            RSP: begin
                d.addr = m_rsp.addr;
                d.data = m_rsp.data;
            end
            REQ: begin
                d.addr = src.addr;
                d.id   = src.id;
            end
            DMA_REQ: begin
                d.addr  = m_dma.addr;
                d.write = m_dma.write;
                d.data  = m_dma.data;
            end
            default: ;
        endcase
        case (d.kind)
            FLUSH_RESUME, RSP, REQ, DMA_REQ: d.look = 1'b1;
            DMA_READ_RESUME, DMA_WRITE_RESUME: d.look = !c.recall_pending;
            default: d.look = 1'b0;
        endcase
        d.valid = (d.kind != NONE);
        return d;
    endfunction

    task automatic apply_decision(input llc_dispatch_t d);
        case (d.kind)
            RST: m_occ[3] = 1'b0;
            RSP: m_occ[2] = 1'b0;
            REQ: begin
                if (m_ctrl.req_in_stalled_valid) m_ctrl.req_in_stalled_valid = 1'b0;
                else m_occ[1] = 1'b0;
            end
            DMA_REQ: m_occ[0] = 1'b0;
            RST_RESUME: m_ctrl.rst_stall = 1'b0;
            FLUSH_RESUME: m_ctrl.flush_stall = 1'b0;
            DMA_READ_RESUME: m_ctrl.dma_read_pending = 1'b0;
            DMA_WRITE_RESUME: begin
                m_ctrl.dma_write_pending = 1'b0;
                if (!m_ctrl.recall_pending) m_occ[0] = 1'b0;
            end
            default: ;
        endcase
        if (d.kind inside {RST_RESUME, FLUSH_RESUME, DMA_READ_RESUME, DMA_WRITE_RESUME} &&
            m_ctrl.recall_pending) begin
            m_ctrl.recall_pending = 1'b0;
            m_ctrl.recall_valid   = 1'b0;
        end
    endtask

    task automatic cfg_write(input logic [1:0] addr, input logic [31:0] wdata);
        @(posedge clk);
        #1;
        cfg_wr    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = wdata;
        @(posedge clk);
        #1;
        cfg_wr = 1'b0;
        case (addr)
            2'd0: begin
                m_ctrl.rst_stall   = wdata[0];
                m_ctrl.flush_stall = wdata[1];
                m_ctrl.req_stall   = wdata[2];
            end
            2'd1: begin
                m_ctrl.recall_pending = wdata[0];
                m_ctrl.recall_valid   = wdata[1];
            end
            2'd2: begin
                m_ctrl.dma_read_pending  = wdata[0];
                m_ctrl.dma_write_pending = wdata[1];
            end
            default: begin
                m_stalled.addr = wdata[`LLC_ADDR_BITS-1:0];
                m_stalled.id   = wdata[`LLC_ADDR_BITS +: `LLC_ID_BITS];
                m_ctrl.req_in_stalled_valid = 1'b1;
            end
        endcase
    endtask

    // Mask bits run rst_tb, rsp, req, dma from the top. Only empty buffers are pushed.
    task automatic push_msgs(input logic [3:0] mask, input llc_rst_tb_t a, input llc_rsp_t b,
                             input llc_req_t c, input llc_dma_req_t d);
        logic [3:0] exp_ready;
        @(posedge clk);
        #1;
        exp_ready = ~m_occ;
        check_value("push_ready", 64'(exp_ready), 64'({rst_tb_in_ready, rsp_in_ready,
                                                        req_in_ready, dma_req_in_ready}));
        {rst_tb_in_valid, rsp_in_valid, req_in_valid, dma_req_in_valid} = mask;
        rst_tb_in  = a;
        rsp_in     = b;
        req_in     = c;
        dma_req_in = d;
        @(posedge clk);
        #1;
        {rst_tb_in_valid, rsp_in_valid, req_in_valid, dma_req_in_valid} = 4'b0;
        if (mask[3]) m_rst_tb = a;
        if (mask[2]) m_rsp = b;
        if (mask[1]) m_req = c;
        if (mask[0]) m_dma = d;
        m_occ = m_occ | mask;
    endtask

    task automatic decode(input string name);
        @(posedge clk);
        #1;
        @(posedge clk);
        #1;
        exp_next  = ref_dispatch(m_ctrl, m_occ);
        exp_name  = name;
        decode_en = 1'b1;
        apply_decision(exp_next);
        @(posedge clk);
        #1;
        decode_en = 1'b0;
        repeat (3) @(posedge clk);
    endtask

    // Dispatch is due in the second cycle after decode_en.
    always @(negedge clk) begin
        if (due) begin
            check_value(name_b, 64'(exp_b), 64'(dispatch));
        end else if (dispatch.valid) begin
            errors++;
            $display("Dispatch valid without a decode two cycles earlier at %0t", $time);
        end
        due    = pend;
        exp_b  = exp_a;
        name_b = name_a;
        pend   = decode_en;
        exp_a  = exp_next;
        name_a = exp_name;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired before the tests finished");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        llc_rst_tb_t  a;
        llc_rsp_t     b;
        llc_req_t     c;
        llc_dma_req_t d;
        logic [31:0]  v;
        logic [31:0]  w;
        logic [3:0]   mask;
        int           r;
        clk = 1'b0;
        rst = 1'b0;
        {rst_tb_in_valid, rsp_in_valid, req_in_valid, dma_req_in_valid} = 4'b0;
        rst_tb_in  = '0;
        rsp_in     = '0;
        req_in     = '0;
        dma_req_in = '0;
        cfg_wr     = 1'b0;
        cfg_addr   = '0;
        cfg_wdata  = '0;
        decode_en  = 1'b0;
        m_ctrl     = '0;
        m_occ      = '0;
        m_rst_tb   = '0;
        m_rsp      = '0;
        m_req      = '0;
        m_stalled  = '0;
        m_dma      = '0;
        errors     = 0;
        lfsr_state = 16'd83;
        exp_next   = '0;
        exp_a      = '0;
        exp_b      = '0;
        pend       = 1'b0;
        due        = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b1;

        @(posedge clk);
        #1;
        check_value("reset_ready", 64'hF, 64'({rst_tb_in_ready, rsp_in_ready,
                                                req_in_ready, dma_req_in_ready}));
        check_value("reset_dispatch", 64'h0, 64'(dispatch.valid));

        // Priority order with all four buffers full.
        a = '{is_flush: 1'b1};
        b = '{addr: 16'h1234, data: 32'hCAFE_0001};
        c = '{addr: 16'h2345, id: 4'h6};
        d = '{addr: 16'h3456, write: 1'b1, data: 32'h0BAD_F00D};
        push_msgs(4'hF, a, b, c, d);
        repeat (5) decode("priority");

        // Stalls.
        cfg_write(2'd0, 32'h4);
        push_msgs(4'h7, a, '{addr: 16'h4321, data: 32'h1111_2222}, c, d);
        decode("stall_rsp");
        decode("stall_blocked");
        cfg_write(2'd0, 32'h3);
        repeat (4) decode("stall_resume");

        // Stalled slot and DMA resumes.
        push_msgs(4'h2, a, b, '{addr: 16'h5678, id: 4'h2}, d);
        cfg_write(2'd3, 32'h0005_ABCD);
        decode("slot_first");
        decode("slot_fresh");
        cfg_write(2'd2, 32'h1);
        decode("dma_read_resume");
        cfg_write(2'd2, 32'h2);
        push_msgs(4'h1, a, b, c, '{addr: 16'h6789, write: 1'b0, data: 32'h5555_AAAA});
        decode("dma_write_resume");
        decode("dma_empty");

        // Recall.
        cfg_write(2'd1, 32'h1);
        push_msgs(4'h6, a, '{addr: 16'h7777, data: 32'h7777_0000}, c, d);
        decode("recall_rsp");
        decode("recall_blocked");
        cfg_write(2'd2, 32'h1);
        cfg_write(2'd1, 32'h3);
        decode("recall_resume");
        decode("recall_cleared");

        for (r = 0; r < 60; r++) begin
            rand_bits(4, v);
            mask = v[3:0] & ~m_occ;
            rand_bits(1, v);
            a.is_flush = v[0];
            rand_bits(16, v);
            b.addr = v[`LLC_ADDR_BITS-1:0];
            rand_bits(32, v);
            b.data = v;
            rand_bits(20, v);
            c = v[19:0];
            rand_bits(17, v);
            d.addr  = v[`LLC_ADDR_BITS-1:0];
            d.write = v[16];
            rand_bits(32, v);
            d.data = v;
            if (mask != 4'h0) push_msgs(mask, a, b, c, d);
            rand_bits(2, v);
            if (v[1:0] == 2'd0) begin
                rand_bits(2, v);
                rand_bits(20, w);
                cfg_write(v[1:0], w);
            end
            decode("random");
        end

        repeat (4) @(posedge clk);
        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+verilog
verilog/llc_pkg.sv
verilog/llc_input_buffer.sv
verilog/llc_ctrl_regs.sv
verilog/llc_input_decoder.sv
verilog/llc_msg_select.sv
verilog/llc_front_end.sv
verification/llc_front_end_checker.sv
verification/llc_front_end_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= llc_front_end_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
